//--- design/beat_distributor.sv
`timescale 1ns/1ps

module beat_distributor (
	input  logic                                  aclk,
	input  logic                                  aresetn,
	input  tpu_load_pkg::region_sel_t             region_sel_i,
	input  logic                                  region_start_i,
	input  logic                                  beat_valid_i,
	input  logic [tpu_load_pkg::DATA_WIDTH-1:0]   beat_i,
	output tpu_load_pkg::buf_wr_t                 buf_wr_o
);

	localparam int N     = tpu_load_pkg::N_CONV_UNIT;
	localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

	logic [PTR_W-1:0]                      ptr_q;
	logic [N-1:0]                          wei_we_q;
	logic [N-1:0]                          ftm_we_q;
	logic [tpu_load_pkg::DATA_WIDTH-1:0]   data_q;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			ptr_q    <= '0;
			wei_we_q <= '0;
			ftm_we_q <= '0;
		end else begin
			wei_we_q <= '0;
			ftm_we_q <= '0;
			if (region_start_i) begin
				ptr_q <= '0;
			end else if (beat_valid_i) begin
				// Round robin over the units.
				if (ptr_q == PTR_W'(N - 1)) begin
					ptr_q <= '0;
				end else begin
					ptr_q <= ptr_q + 1'b1;
				end
			end
			if (beat_valid_i) begin
				if (region_sel_i == tpu_load_pkg::REGION_WEI) begin
					wei_we_q[ptr_q] <= 1'b1;
				end else begin
					ftm_we_q[ptr_q] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (beat_valid_i) begin
			data_q <= beat_i;
		end
	end

	assign buf_wr_o.wei_we = wei_we_q;
	assign buf_wr_o.ftm_we = ftm_we_q;
	assign buf_wr_o.data   = data_q;

endmodule

//--- design/layer_desc_regs.sv
`timescale 1ns/1ps

module layer_desc_regs (
	input  logic                      aclk,
	input  logic                      aresetn,
	input  logic                      desc_wr_i,
	input  tpu_load_pkg::layer_desc_t desc_i,
	input  logic                      busy_i,
	output tpu_load_pkg::layer_desc_t desc_o,
	output logic                      start_o
);

	tpu_load_pkg::layer_desc_t desc_q;
	logic                      start_q;
	logic                      accept;

	// Writes are dropped while a layer is in flight.
	assign accept = desc_wr_i & ~busy_i;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			start_q <= 1'b0;
		end else begin
			start_q <= accept;
		end
	end

	// Descriptor payload.
	always_ff @(posedge aclk) begin
		if (accept) begin
			desc_q <= desc_i;
		end
	end

	assign desc_o  = desc_q;
	assign start_o = start_q;

endmodule

//--- design/load_sequencer.sv
`timescale 1ns/1ps

module load_sequencer (
	input  logic                      aclk,
	input  logic                      aresetn,
	input  logic                      start_i,
	input  tpu_load_pkg::rd_req_t     wei_chunk_i,
	input  tpu_load_pkg::rd_req_t     ftm_chunk_i,
	input  logic                      wei_empty_i,
	input  logic                      ftm_empty_i,
	input  logic                      rd_done_i,
	output logic                      wei_advance_o,
	output logic                      ftm_advance_o,
	output logic                      rd_req_valid_o,
	output tpu_load_pkg::rd_req_t     rd_req_o,
	output tpu_load_pkg::region_sel_t region_sel_o,
	output logic                      region_start_o,
	output logic                      busy_o,
	output logic                      layer_done_o
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WEI_CHECK,
		ST_WEI_WAIT,
		ST_FTM_CHECK,
		ST_FTM_WAIT,
		ST_DONE
	} state_t;

	state_t                    state_q;
	logic                      first_q;
	logic                      req_valid_q;
	logic                      region_start_q;
	tpu_load_pkg::region_sel_t region_sel_q;
	tpu_load_pkg::rd_req_t     req_q;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			state_q        <= ST_IDLE;
			first_q        <= 1'b0;
			req_valid_q    <= 1'b0;
			region_start_q <= 1'b0;
			region_sel_q   <= tpu_load_pkg::REGION_WEI;
		end else begin
			req_valid_q    <= 1'b0;
			region_start_q <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (start_i) begin
						first_q <= 1'b1;
						state_q <= ST_WEI_CHECK;
					end
				end
				ST_WEI_CHECK: begin
					if (wei_empty_i) begin
						first_q <= 1'b1;
						state_q <= ST_FTM_CHECK;
					end else begin
						req_valid_q    <= 1'b1;
						region_start_q <= first_q;
						region_sel_q   <= tpu_load_pkg::REGION_WEI;
						first_q        <= 1'b0;
						state_q        <= ST_WEI_WAIT;
					end
				end
				ST_WEI_WAIT: begin
					if (rd_done_i) begin
						state_q <= ST_WEI_CHECK;
					end
				end
				ST_FTM_CHECK: begin
					if (ftm_empty_i) begin
						state_q <= ST_DONE;
					end else begin
						req_valid_q    <= 1'b1;
						region_start_q <= first_q;
						region_sel_q   <= tpu_load_pkg::REGION_FTM;
						first_q        <= 1'b0;
						state_q        <= ST_FTM_WAIT;
					end
				end
				ST_FTM_WAIT: begin
					if (rd_done_i) begin
						state_q <= ST_FTM_CHECK;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// Request payload follows the active chunker.
	always_ff @(posedge aclk) begin
		if (state_q == ST_WEI_CHECK) begin
			req_q <= wei_chunk_i;
		end else if (state_q == ST_FTM_CHECK) begin
			req_q <= ftm_chunk_i;
		end
	end

	// Advance as soon as memory finishes, so the next chunk is ready in the check state.
	assign wei_advance_o = (state_q == ST_WEI_WAIT) & rd_done_i;
	assign ftm_advance_o = (state_q == ST_FTM_WAIT) & rd_done_i;

	assign rd_req_valid_o = req_valid_q;
	assign rd_req_o       = req_q;
	assign region_sel_o   = region_sel_q;
	assign region_start_o = region_start_q;

	// Start pulse counts as busy so a second write is blocked.
	assign busy_o       = (state_q != ST_IDLE) | start_i;
	assign layer_done_o = (state_q == ST_DONE);

endmodule

//--- design/region_chunker.sv
`timescale 1ns/1ps

module region_chunker (
	input  logic                  aclk,
	input  logic                  aresetn,
	input  logic                  load_i,
	input  tpu_load_pkg::region_t region_i,
	input  logic                  advance_i,
	output tpu_load_pkg::rd_req_t chunk_o,
	output logic                  empty_o
);

	localparam int AW = tpu_load_pkg::ADDR_WIDTH;
	localparam int NW = tpu_load_pkg::NBURST_WIDTH;
	localparam logic [NW-1:0] MAX_CHUNK = NW'(tpu_load_pkg::UNIT_BURSTS);

	logic [AW-1:0] addr_q;
	logic [NW-1:0] rema_q;
	logic [NW-1:0] chunk_n;
	logic [AW-1:0] chunk_bytes;

	// Size of the current chunk.
	assign chunk_n = (rema_q > MAX_CHUNK) ? MAX_CHUNK : rema_q;

	assign chunk_bytes = AW'(chunk_n) << tpu_load_pkg::BURST_SHIFT;

	// Bursts left in the region.
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			rema_q <= '0;
		end else if (load_i) begin
			rema_q <= region_i.n_bursts;
		end else if (advance_i) begin
			rema_q <= rema_q - chunk_n;
		end
	end

	// Address of the next chunk.
	always_ff @(posedge aclk) begin
		if (load_i) begin
			addr_q <= region_i.addr;
		end else if (advance_i) begin
			addr_q <= addr_q + chunk_bytes;
		end
	end

	assign chunk_o.addr     = addr_q;
	assign chunk_o.n_bursts = chunk_n;
	assign empty_o          = (rema_q == '0);

endmodule

//--- design/tpu_load_pkg.sv
package tpu_load_pkg;

	// Number of convolution units fed by the loader.
	localparam int N_CONV_UNIT = 4;

	// Read data path.
	localparam int DATA_WIDTH      = 64;
	localparam int BEATS_PER_BURST = 16;
	localparam int BYTES_PER_BURST = BEATS_PER_BURST * DATA_WIDTH / 8;
	localparam int BURST_SHIFT     = $clog2(BYTES_PER_BURST);

	// Largest read request, in bursts. Must be a power of two.
	localparam int UNIT_BURSTS = 4;

	localparam int ADDR_WIDTH   = 32;
	localparam int NBURST_WIDTH = 16;

	// One region of external memory.
	typedef struct packed {
		logic [ADDR_WIDTH-1:0]   addr;
		logic [NBURST_WIDTH-1:0] n_bursts;
	} region_t;

	// Layer descriptor with the weight region first.
	typedef struct packed {
		region_t wei;
		region_t ftm;
	} layer_desc_t;

	// One read request towards memory.
	typedef struct packed {
		logic [ADDR_WIDTH-1:0]   addr;
		logic [NBURST_WIDTH-1:0] n_bursts;
	} rd_req_t;

	// One write into the unit buffers.
	typedef struct packed {
		logic [N_CONV_UNIT-1:0] wei_we;
		logic [N_CONV_UNIT-1:0] ftm_we;
		logic [DATA_WIDTH-1:0]  data;
	} buf_wr_t;

	// Region currently being fetched.
	typedef enum logic {
		REGION_WEI = 1'b0,
		REGION_FTM = 1'b1
	} region_sel_t;

endpackage

//--- design/tpu_load_top.sv
`timescale 1ns/1ps

module tpu_load_top (
	input  logic                                aclk,
	input  logic                                aresetn,
	input  logic                                desc_wr_i,
	input  tpu_load_pkg::layer_desc_t           desc_i,
	output logic                                rd_req_valid_o,
	output tpu_load_pkg::rd_req_t               rd_req_o,
	input  logic                                rd_done_i,
	input  logic                                beat_valid_i,
	input  logic [tpu_load_pkg::DATA_WIDTH-1:0] beat_i,
	output tpu_load_pkg::buf_wr_t               buf_wr_o,
	output logic                                busy_o,
	output logic                                layer_done_o
);

	tpu_load_pkg::layer_desc_t desc;
	tpu_load_pkg::rd_req_t     wei_chunk;
	tpu_load_pkg::rd_req_t     ftm_chunk;
	tpu_load_pkg::region_sel_t region_sel;
	logic                      start;
	logic                      busy;
	logic                      wei_empty;
	logic                      ftm_empty;
	logic                      wei_advance;
	logic                      ftm_advance;
	logic                      region_start;

	layer_desc_regs u_desc_regs (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.desc_wr_i (desc_wr_i),
		.desc_i    (desc_i),
		.busy_i    (busy),
		.desc_o    (desc),
		.start_o   (start)
	);

	// Both chunkers load at layer start.
	region_chunker wei_chunker (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.load_i    (start),
		.region_i  (desc.wei),
		.advance_i (wei_advance),
		.chunk_o   (wei_chunk),
		.empty_o   (wei_empty)
	);

	region_chunker ftm_chunker (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.load_i    (start),
		.region_i  (desc.ftm),
		.advance_i (ftm_advance),
		.chunk_o   (ftm_chunk),
		.empty_o   (ftm_empty)
	);

	load_sequencer u_sequencer (
		.aclk           (aclk),
		.aresetn        (aresetn),
		.start_i        (start),
		.wei_chunk_i    (wei_chunk),
		.ftm_chunk_i    (ftm_chunk),
		.wei_empty_i    (wei_empty),
		.ftm_empty_i    (ftm_empty),
		.rd_done_i      (rd_done_i),
		.wei_advance_o  (wei_advance),
		.ftm_advance_o  (ftm_advance),
		.rd_req_valid_o (rd_req_valid_o),
		.rd_req_o       (rd_req_o),
		.region_sel_o   (region_sel),
		.region_start_o (region_start),
		.busy_o         (busy),
		.layer_done_o   (layer_done_o)
	);

	beat_distributor u_distributor (
		.aclk           (aclk),
		.aresetn        (aresetn),
		.region_sel_i   (region_sel),
		.region_start_i (region_start),
		.beat_valid_i   (beat_valid_i),
		.beat_i         (beat_i),
		.buf_wr_o       (buf_wr_o)
	);

	assign busy_o = busy;

endmodule

//--- flist.f
design/tpu_load_pkg.sv
design/layer_desc_regs.sv
design/region_chunker.sv
design/load_sequencer.sv
design/beat_distributor.sv
design/tpu_load_top.sv
test/tb_checker.sv
test/tb_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_top -Mdir obj_dir -o tb_sim -f flist.f
output=$(./obj_dir/tb_sim)
echo "$output"
if echo "$output" | grep -q "Regression passed"; then
	exit 0
fi
exit 1

//--- test/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
	input  logic                      aclk,
	input  logic                      aresetn,
	input  logic                      desc_wr_i,
	input  tpu_load_pkg::layer_desc_t desc_i,
	input  logic                      busy_i,
	input  logic                      rd_req_valid_i,
	input  tpu_load_pkg::rd_req_t     rd_req_i,
	input  tpu_load_pkg::buf_wr_t     buf_wr_i,
	input  logic                      layer_done_i,
	output int                        error_count_o,
	output int                        check_count_o
);

	localparam int N = tpu_load_pkg::N_CONV_UNIT;

	tpu_load_pkg::rd_req_t exp_req_q [$];
	tpu_load_pkg::buf_wr_t exp_wr_q [$];
	logic                  in_flight = 1'b0;
	int                    error_count = 0;
	int                    check_count = 0;

	assign error_count_o = error_count;
	assign check_count_o = check_count;

	// Splits a region into chunks of at most UNIT_BURSTS and deals its beats from unit 0.
	function automatic void expand_region(input tpu_load_pkg::region_t r, input logic is_map);
		tpu_load_pkg::rd_req_t req;
		tpu_load_pkg::buf_wr_t wr;
		logic [31:0]           addr;
		int                    remaining;
		int                    chunk;
		int                    beat_k;
		int                    j;
		addr      = r.addr;
		remaining = int'(r.n_bursts);
		beat_k    = 0;
		while (remaining > 0) begin
			chunk        = (remaining < tpu_load_pkg::UNIT_BURSTS) ? remaining
				: tpu_load_pkg::UNIT_BURSTS;
			req.addr     = addr;
			req.n_bursts = 16'(chunk);
			exp_req_q.push_back(req);
			for (j = 0; j < chunk * tpu_load_pkg::BEATS_PER_BURST; j++) begin
				wr.wei_we = is_map ? '0 : N'(1) << (beat_k % N);
				wr.ftm_we = is_map ? N'(1) << (beat_k % N) : '0;
				wr.data   = 64'(addr) + 64'(8 * j);
				exp_wr_q.push_back(wr);
				beat_k++;
			end
			addr      = addr + 32'(chunk * tpu_load_pkg::BYTES_PER_BURST);
			remaining = remaining - chunk;
		end
	endfunction

	// Weights are fetched before the feature map.
	function automatic void expand_layer(input tpu_load_pkg::layer_desc_t d);
		expand_region(d.wei, 1'b0);
		expand_region(d.ftm, 1'b1);
	endfunction

	function automatic void compare_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			error_count++;
			$display("[ERROR] %s expected 0x%h got 0x%h", name, expected, actual);
		end
	endfunction

	always @(negedge aclk) begin
		tpu_load_pkg::rd_req_t exp_req;
		tpu_load_pkg::buf_wr_t exp_wr;
		if (!aresetn) begin
			in_flight = 1'b0;
		end else begin
			compare_value("busy_o", 64'(in_flight), 64'(busy_i));
			if (rd_req_valid_i) begin
				if (exp_req_q.size() == 0) begin
					error_count++;
					$display("Read request to 0x%h was not expected", rd_req_i.addr);
				end else begin
					exp_req = exp_req_q.pop_front();
					check_count++;
					compare_value("rd_req_o.addr", 64'(exp_req.addr), 64'(rd_req_i.addr));
					compare_value("rd_req_o.n_bursts", 64'(exp_req.n_bursts),
						64'(rd_req_i.n_bursts));
				end
			end
			if ((buf_wr_i.wei_we != '0) || (buf_wr_i.ftm_we != '0)) begin
				if (exp_wr_q.size() == 0) begin
					error_count++;
					$display("Buffer write of 0x%h was not expected", buf_wr_i.data);
				end else begin
					exp_wr = exp_wr_q.pop_front();
					check_count++;
					compare_value("buf_wr_o.wei_we", 64'(exp_wr.wei_we), 64'(buf_wr_i.wei_we));
					compare_value("buf_wr_o.ftm_we", 64'(exp_wr.ftm_we), 64'(buf_wr_i.ftm_we));
					compare_value("buf_wr_o.data", exp_wr.data, buf_wr_i.data);
				end
			end
			if (layer_done_i) begin
				if (!in_flight) begin
					error_count++;
					$display("layer_done_o pulsed with no layer in flight");
				end else if ((exp_req_q.size() != 0) || (exp_wr_q.size() != 0)) begin
					error_count++;
					$display("Layer finished with %0d requests and %0d buffer writes missing",
						exp_req_q.size(), exp_wr_q.size());
				end
				in_flight = 1'b0;
			end else if (desc_wr_i && !in_flight) begin
				// Writes during a layer are dropped.
				expand_layer(desc_i);
				in_flight = 1'b1;
			end
		end
	end

endmodule

//--- test/tb_top.sv
`timescale 1ns/1ps

module tb_top;

	localparam int N_TESTS    = 16;
	localparam int MODE_IDLE  = 0;
	localparam int MODE_LAYER = 1;
	localparam int MODE_BUSY  = 2;

	logic                                aclk = 1'b0;
	logic                                aresetn;
	logic                                desc_wr;
	tpu_load_pkg::layer_desc_t           desc;
	logic                                rd_req_valid;
	tpu_load_pkg::rd_req_t               rd_req;
	logic                                rd_done;
	logic                                beat_valid;
	logic [tpu_load_pkg::DATA_WIDTH-1:0] beat;
	tpu_load_pkg::buf_wr_t               buf_wr;
	logic                                busy;
	logic                                layer_done;
	int                                  error_count;
	int                                  check_count;

	tpu_load_pkg::layer_desc_t test_desc [N_TESTS];
	int                        test_mode [N_TESTS];
	string                     test_name [N_TESTS];
	tpu_load_pkg::layer_desc_t busy_desc;
	int                        timeout_cycles = 0;

	tpu_load_top UUT (
		.aclk           (aclk),
		.aresetn        (aresetn),
		.desc_wr_i      (desc_wr),
		.desc_i         (desc),
		.rd_req_valid_o (rd_req_valid),
		.rd_req_o       (rd_req),
		.rd_done_i      (rd_done),
		.beat_valid_i   (beat_valid),
		.beat_i         (beat),
		.buf_wr_o       (buf_wr),
		.busy_o         (busy),
		.layer_done_o   (layer_done)
	);

	tb_checker u_checker (
		.aclk           (aclk),
		.aresetn        (aresetn),
		.desc_wr_i      (desc_wr),
		.desc_i         (desc),
		.busy_i         (busy),
		.rd_req_valid_i (rd_req_valid),
		.rd_req_i       (rd_req),
		.buf_wr_i       (buf_wr),
		.layer_done_i   (layer_done),
		.error_count_o  (error_count),
		.check_count_o  (check_count)
	);

	always #20 aclk = ~aclk;

	function automatic tpu_load_pkg::layer_desc_t make_desc(input logic [31:0] wei_addr,
			input int wei_bursts, input logic [31:0] ftm_addr, input int ftm_bursts);
		tpu_load_pkg::layer_desc_t d;
		d.wei.addr     = wei_addr;
		d.wei.n_bursts = 16'(wei_bursts);
		d.ftm.addr     = ftm_addr;
		d.ftm.n_bursts = 16'(ftm_bursts);
		return d;
	endfunction

	// Directed layers first, then random ones.
	function automatic void build_tests();
		int t;
		test_name[0] = "idle after reset";
		test_mode[0] = MODE_IDLE;
		test_desc[0] = '0;
		test_name[1] = "small layer";
		test_mode[1] = MODE_LAYER;
		test_desc[1] = make_desc(32'h0000_1000, 3, 32'h0002_0000, 2);
		test_name[2] = "region split";
		test_mode[2] = MODE_LAYER;
		test_desc[2] = make_desc(32'h0004_0000, 10, 32'h0008_0000, 6);
		test_name[3] = "round robin";
		test_mode[3] = MODE_LAYER;
		test_desc[3] = make_desc(32'h0000_0A80, 1, 32'h0000_0F00, 1);
		test_name[4] = "empty weight region";
		test_mode[4] = MODE_LAYER;
		test_desc[4] = make_desc(32'h0000_3000, 0, 32'h0000_9000, 5);
		test_name[5] = "write while busy";
		test_mode[5] = MODE_BUSY;
		test_desc[5] = make_desc(32'h0000_5000, 2, 32'h0000_6000, 2);
		busy_desc    = make_desc(32'h0000_7000, 4, 32'h0000_7800, 4);
		for (t = 6; t < N_TESTS; t++) begin
			test_name[t] = $sformatf("random layer %0d", t - 5);
			test_mode[t] = MODE_LAYER;
			test_desc[t] = make_desc($urandom & 32'h0FFF_FF80, int'($urandom % 13),
				$urandom & 32'h0FFF_FF80, int'($urandom % 13));
		end
	endfunction

	function automatic int count_beats();
		int t;
		int bursts;
		bursts = 0;
		for (t = 0; t < N_TESTS; t++) begin
			if (test_mode[t] != MODE_IDLE) begin
				bursts += int'(test_desc[t].wei.n_bursts) + int'(test_desc[t].ftm.n_bursts);
			end
		end
		return bursts * tpu_load_pkg::BEATS_PER_BURST;
	endfunction

	task automatic write_desc(input tpu_load_pkg::layer_desc_t d);
		@(posedge aclk);
		desc_wr <= 1'b1;
		desc    <= d;
		@(posedge aclk);
		desc_wr <= 1'b0;
	endtask

	task automatic wait_layer_done();
		do begin
			@(negedge aclk);
		end while (!layer_done);
	endtask

	task automatic run_test(input int t);
		if (test_mode[t] == MODE_IDLE) begin
			repeat (20) @(posedge aclk);
		end else begin
			write_desc(test_desc[t]);
			// Second write lands while the first layer is still loading.
			if (test_mode[t] == MODE_BUSY) begin
				repeat (4) @(posedge aclk);
				write_desc(busy_desc);
			end
			wait_layer_done();
			repeat (5) @(posedge aclk);
		end
	endtask

	// Memory model that serves one request at a time.
	task automatic serve_request(input tpu_load_pkg::rd_req_t req);
		int n_beats;
		int gap;
		int i;
		n_beats = int'(req.n_bursts) * tpu_load_pkg::BEATS_PER_BURST;
		for (i = 0; i < n_beats; i++) begin
			gap = int'($urandom % 3);
			repeat (gap) begin
				@(posedge aclk);
				beat_valid <= 1'b0;
			end
			@(posedge aclk);
			beat_valid <= 1'b1;
			beat       <= 64'(req.addr) + 64'(8 * i);
		end
		@(posedge aclk);
		beat_valid <= 1'b0;
		rd_done    <= 1'b1;
		@(posedge aclk);
		rd_done <= 1'b0;
	endtask

	initial begin
		rd_done    <= 1'b0;
		beat_valid <= 1'b0;
		beat       <= '0;
		forever begin
			@(negedge aclk);
			if (aresetn && rd_req_valid) begin
				serve_request(rd_req);
			end
		end
	end

	initial begin
		wait (timeout_cycles > 0);
		repeat (timeout_cycles) @(posedge aclk);
		$display("Timeout after %0d cycles, the DUT stopped answering", timeout_cycles);
		$display("Regression failed");
		$finish;
	end

	initial begin
		int t;
		int errors_before;
		int checks_before;
		int failed;
		aresetn <= 1'b0;
		desc_wr <= 1'b0;
		desc    <= '0;
		failed  = 0;
		void'($urandom(62221));
		build_tests();
		timeout_cycles = 20 * count_beats() + 200 * N_TESTS;
		repeat (5) @(posedge aclk);
		aresetn <= 1'b1;
		for (t = 0; t < N_TESTS; t++) begin
			errors_before = error_count;
			checks_before = check_count;
			run_test(t);
			if (error_count == errors_before) begin
				$display("Test %0d %s: ok, %0d checks", t, test_name[t],
					check_count - checks_before);
			end else begin
				failed++;
				$display("Test %0d %s: FAILED, %0d errors", t, test_name[t],
					error_count - errors_before);
			end
		end
		$display("Tests %0d, failed %0d, checks %0d, errors %0d", N_TESTS, failed,
			check_count, error_count);
		if ((error_count == 0) && (check_count > 0)) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule
